/* dv/instr_decode_checker.sv */
`timescale 1ns/100ps
`default_nettype none

// handshake properties of decode_stage
module instr_decode_checker
    import core_types_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           in_valid_i,
    input  logic           in_ready_i,
    input  logic           out_valid_i,
    input  logic           out_ready_i,
    input  decode_result_t out_data_i
);

    // read back by the testbench at the end of the run
    int assert_errors = 0;

    // stalled output holds its valid and data
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else begin
        $error("output changed while stalled by downstream");
        assert_errors++;
    end

    // nothing valid right after a reset edge
    assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i)
    else begin
        $error("out_valid_o high in the cycle after reset");
        assert_errors++;
    end

    // drained with nothing new coming in leaves the register empty and ready
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i && out_ready_i && !(in_valid_i && in_ready_i)
        |=> !out_valid_i && in_ready_i)
    else begin
        $error("stage register not empty and ready after a drain with no new input");
        assert_errors++;
    end

endmodule

`default_nettype wire

/* dv/instr_decode_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decode_tb
    import core_types_pkg::*;
    import decode_ops_pkg::*;
();

    localparam int NUM_INSTR  = 2000;
    // about five times the expected run length at ~50% throughput
    localparam int MAX_CYCLES = NUM_INSTR * 10;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               in_valid;
    instr_buffer_info_t in_data;
    logic               in_ready;
    logic               out_valid;
    decode_result_t     out_data;
    logic               out_ready;

    integer             seed = 32'h3897_9463;
    int                 errors = 0;
    int                 cycles = 0;
    int                 sent = 0;
    int                 received = 0;
    decode_result_t     expected_q[$];
    string              name_q[$];
    string              offer_name;

    always #4 clk = ~clk;

    instr_decode_top i_instr_decode_top (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .in_valid_i  (in_valid),
        .in_data_i   (in_data),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .out_data_o  (out_data),
        .out_ready_i (out_ready)
    );

    bind decode_stage instr_decode_checker i_checker (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_i  (in_ready_o),
        .out_valid_i (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_i  (out_data_o)
    );

    // register-register form reading rk and rj
    function automatic decode_result_t reg_reg(logic [31:0] w, logic [ALU_OP_WIDTH-1:0] op,
                                               logic [ALU_SEL_WIDTH-1:0] sel);
        decode_result_t e;
        e = '0;
        e.reg_read_valid  = 2'b11;
        e.reg_read_addr   = {w[14:10], w[9:5]};
        e.reg_write_valid = 1'b1;
        e.reg_write_addr  = w[4:0];
        e.aluop           = op;
        e.alusel          = sel;
        return e;
    endfunction

    // rj source with a 12 bit immediate and caller-chosen extension
    function automatic decode_result_t imm12_op(logic [31:0] w, logic [ALU_OP_WIDTH-1:0] op,
                                                logic [ALU_SEL_WIDTH-1:0] sel, bit sign);
        decode_result_t e;
        e = '0;
        e.reg_read_valid  = 2'b01;
        e.reg_read_addr   = {5'd0, w[9:5]};
        e.reg_write_valid = 1'b1;
        e.reg_write_addr  = w[4:0];
        e.use_imm         = 1'b1;
        e.imm             = sign ? {{20{w[21]}}, w[21:10]} : {20'd0, w[21:10]};
        e.aluop           = op;
        e.alusel          = sel;
        return e;
    endfunction

    function automatic decode_result_t expected_decode(instr_buffer_info_t info);
        decode_result_t e;
        logic [31:0]    w;
        w = info.instr;
        e = '0;
        e.illegal = 1'b1;
        case (w[31:15])
            OPC_ADD_W:  e = reg_reg(w, ALU_OP_ADD, SEL_ARITH);
            OPC_SUB_W:  e = reg_reg(w, ALU_OP_SUB, SEL_ARITH);
            OPC_AND:    e = reg_reg(w, ALU_OP_AND, SEL_LOGIC);
            OPC_OR:     e = reg_reg(w, ALU_OP_OR, SEL_LOGIC);
            OPC_XOR:    e = reg_reg(w, ALU_OP_XOR, SEL_LOGIC);
            OPC_SLL_W:  e = reg_reg(w, ALU_OP_SLL, SEL_SHIFT);
            OPC_SRL_W:  e = reg_reg(w, ALU_OP_SRL, SEL_SHIFT);
            OPC_SRA_W:  e = reg_reg(w, ALU_OP_SRA, SEL_SHIFT);
            OPC_SLLI_W: e = reg_reg(w, ALU_OP_SLL, SEL_SHIFT);
            OPC_SRLI_W: e = reg_reg(w, ALU_OP_SRL, SEL_SHIFT);
            OPC_SRAI_W: e = reg_reg(w, ALU_OP_SRA, SEL_SHIFT);
            default: ;
        endcase
        // shift immediates drop rk and use ui5 instead
        if (w[31:15] inside {OPC_SLLI_W, OPC_SRLI_W, OPC_SRAI_W}) begin
            e.reg_read_valid = 2'b01;
            e.reg_read_addr  = {5'd0, w[9:5]};
            e.use_imm        = 1'b1;
            e.imm            = {27'd0, w[14:10]};
        end
        case (w[31:22])
            OPC_ADDI_W: e = imm12_op(w, ALU_OP_ADD, SEL_ARITH, 1'b1);
            OPC_ANDI:   e = imm12_op(w, ALU_OP_AND, SEL_LOGIC, 1'b0);
            OPC_ORI:    e = imm12_op(w, ALU_OP_OR, SEL_LOGIC, 1'b0);
            OPC_XORI:   e = imm12_op(w, ALU_OP_XOR, SEL_LOGIC, 1'b0);
            OPC_LD_W:   e = imm12_op(w, ALU_OP_LD_W, SEL_MEM, 1'b1);
            OPC_ST_W: begin
                e = imm12_op(w, ALU_OP_ST_W, SEL_MEM, 1'b1);
                e.reg_read_valid  = 2'b11;
                e.reg_read_addr   = {w[4:0], w[9:5]};
                e.reg_write_valid = 1'b0;
                e.reg_write_addr  = '0;
            end
            default: ;
        endcase
        if (w[31:25] == OPC_LU12I_W || w[31:25] == OPC_PCADDU12I) begin
            e = '0;
            e.reg_write_valid = 1'b1;
            e.reg_write_addr  = w[4:0];
            e.use_imm         = 1'b1;
            e.imm             = {w[24:5], 12'd0};
            e.aluop           = (w[31:25] == OPC_LU12I_W) ? ALU_OP_LUI : ALU_OP_PCADDU;
            e.alusel          = SEL_ARITH;
        end
        e.pc = info.pc;
        return e;
    endfunction

    // one of the 19 opcodes or raw bits
    task automatic make_instr(output instr_buffer_info_t info, output string name);
        int          cls;
        logic [31:0] r;
        cls     = {$random(seed)} % 20;
        r       = $random(seed);
        info.pc = $random(seed);
        case (cls)
            0:  begin info.instr = {OPC_ADD_W, r[14:0]};     name = "add.w";     end
            1:  begin info.instr = {OPC_SUB_W, r[14:0]};     name = "sub.w";     end
            2:  begin info.instr = {OPC_AND, r[14:0]};       name = "and";       end
            3:  begin info.instr = {OPC_OR, r[14:0]};        name = "or";        end
            4:  begin info.instr = {OPC_XOR, r[14:0]};       name = "xor";       end
            5:  begin info.instr = {OPC_SLL_W, r[14:0]};     name = "sll.w";     end
            6:  begin info.instr = {OPC_SRL_W, r[14:0]};     name = "srl.w";     end
            7:  begin info.instr = {OPC_SRA_W, r[14:0]};     name = "sra.w";     end
            8:  begin info.instr = {OPC_SLLI_W, r[14:0]};    name = "slli.w";    end
            9:  begin info.instr = {OPC_SRLI_W, r[14:0]};    name = "srli.w";    end
            10: begin info.instr = {OPC_SRAI_W, r[14:0]};    name = "srai.w";    end
            11: begin info.instr = {OPC_ADDI_W, r[21:0]};    name = "addi.w";    end
            12: begin info.instr = {OPC_ANDI, r[21:0]};      name = "andi";      end
            13: begin info.instr = {OPC_ORI, r[21:0]};       name = "ori";       end
            14: begin info.instr = {OPC_XORI, r[21:0]};      name = "xori";      end
            15: begin info.instr = {OPC_LD_W, r[21:0]};      name = "ld.w";      end
            16: begin info.instr = {OPC_ST_W, r[21:0]};      name = "st.w";      end
            17: begin info.instr = {OPC_LU12I_W, r[24:0]};   name = "lu12i.w";   end
            18: begin info.instr = {OPC_PCADDU12I, r[24:0]}; name = "pcaddu12i"; end
            default: begin info.instr = r;                   name = "raw";       end
        endcase
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test, field, exp, act);
            errors++;
        end
    endtask

    task automatic compare_result(input string test, input decode_result_t exp,
                                  input decode_result_t act);
        check_field(test, "illegal", exp.illegal, act.illegal);
        check_field(test, "reg_read_valid", exp.reg_read_valid, act.reg_read_valid);
        check_field(test, "reg_read_addr", exp.reg_read_addr, act.reg_read_addr);
        check_field(test, "use_imm", exp.use_imm, act.use_imm);
        check_field(test, "imm", exp.imm, act.imm);
        check_field(test, "reg_write_valid", exp.reg_write_valid, act.reg_write_valid);
        check_field(test, "reg_write_addr", exp.reg_write_addr, act.reg_write_addr);
        check_field(test, "aluop", exp.aluop, act.aluop);
        check_field(test, "alusel", exp.alusel, act.alusel);
        check_field(test, "pc", exp.pc, act.pc);
    endtask

    initial begin
        instr_buffer_info_t next_info;
        string              next_name;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_field("reset", "out_valid_o", 32'd0, out_valid);
        check_field("reset", "in_ready_o", 32'd1, in_ready);

        while (received < NUM_INSTR && cycles < MAX_CYCLES) begin
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    $display("output transfer with no instruction pending");
                    errors++;
                end else begin
                    compare_result(name_q.pop_front(), expected_q.pop_front(), out_data);
                end
                received++;
            end
            if (in_valid && in_ready) begin
                expected_q.push_back(expected_decode(in_data));
                name_q.push_back(offer_name);
                sent++;
            end
            // downstream stalls about 30% of cycles
            out_ready <= ({$random(seed)} % 10) >= 3;
            if (!in_valid || in_ready) begin
                if (sent < NUM_INSTR && ({$random(seed)} % 4) != 0) begin
                    make_instr(next_info, next_name);
                    offer_name = next_name;
                    in_data  <= next_info;
                    in_valid <= 1'b1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            @(posedge clk);
            cycles++;
        end
        in_valid <= 1'b0;

        if (received < NUM_INSTR) begin
            $display("timeout after %0d cycles, only %0d of %0d results seen",
                     cycles, received, NUM_INSTR);
            errors++;
        end
        if (expected_q.size() != 0) begin
            $display("%0d expected results never came out", expected_q.size());
            errors++;
        end
        $display("errors: %0d, assertion failures: %0d, sent: %0d, received: %0d",
                 errors, i_instr_decode_top.i_decode_stage.i_checker.assert_errors,
                 sent, received);
        if (errors == 0 && i_instr_decode_top.i_decode_stage.i_checker.assert_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* instr_decode_top.f */
logic/decode_ops_pkg.sv
logic/core_types_pkg.sv
logic/decoder_3r.sv
logic/decoder_2ri8.sv
logic/decoder_2ri12.sv
logic/decoder_1ri20.sv
logic/decode_stage.sv
logic/instr_decode_top.sv
dv/instr_decode_checker.sv
dv/instr_decode_tb.sv

/* logic/core_types_pkg.sv */
`default_nettype none

package core_types_pkg;

    // field widths of the ALU control come from the opcode package
    import decode_ops_pkg::*;

    localparam int DATA_WIDTH     = 32;
    localparam int GPR_NUM        = 32;
    localparam int GPR_ADDR_WIDTH = $clog2(GPR_NUM);

    // one fetched instruction with its address
    typedef struct packed {
        logic [DATA_WIDTH-1:0] instr;
        logic [DATA_WIDTH-1:0] pc;
    } instr_buffer_info_t;

    // decode output handed to issue
    typedef struct packed {
        logic                          illegal;
        // {rk, rj}
        logic [1:0]                    reg_read_valid;
        logic [2*GPR_ADDR_WIDTH-1:0]   reg_read_addr;
        logic                          use_imm;
        logic [DATA_WIDTH-1:0]         imm;
        // rd
        logic                          reg_write_valid;
        logic [GPR_ADDR_WIDTH-1:0]     reg_write_addr;
        logic [ALU_OP_WIDTH-1:0]       aluop;
        logic [ALU_SEL_WIDTH-1:0]      alusel;
        logic [DATA_WIDTH-1:0]         pc;
    } decode_result_t;

endpackage

`default_nettype wire

/* logic/decode_ops_pkg.sv */
`default_nettype none

package decode_ops_pkg;

    localparam int ALU_OP_WIDTH  = 8;
    localparam int ALU_SEL_WIDTH = 3;

    // 3R opcodes, instr[31:15]
    localparam logic [16:0] OPC_ADD_W     = 17'h00020;
    localparam logic [16:0] OPC_SUB_W     = 17'h00022;
    localparam logic [16:0] OPC_AND       = 17'h00029;
    localparam logic [16:0] OPC_OR        = 17'h0002A;
    localparam logic [16:0] OPC_XOR       = 17'h0002B;
    localparam logic [16:0] OPC_SLL_W     = 17'h0002E;
    localparam logic [16:0] OPC_SRL_W     = 17'h0002F;
    localparam logic [16:0] OPC_SRA_W     = 17'h00030;

    // shift by immediate, instr[31:15] with bit 15 set
    localparam logic [16:0] OPC_SLLI_W    = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W    = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W    = 17'h00091;

    // 2RI12 opcodes, instr[31:22]
    localparam logic [9:0]  OPC_ADDI_W    = 10'h00A;
    localparam logic [9:0]  OPC_ANDI      = 10'h00D;
    localparam logic [9:0]  OPC_ORI       = 10'h00E;
    localparam logic [9:0]  OPC_XORI      = 10'h00F;
    localparam logic [9:0]  OPC_LD_W      = 10'h0A2;
    localparam logic [9:0]  OPC_ST_W      = 10'h0A6;

    // 1RI20 opcodes, instr[31:25]
    localparam logic [6:0]  OPC_LU12I_W   = 7'h0A;
    localparam logic [6:0]  OPC_PCADDU12I = 7'h0E;

    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_ADD    = 8'h01;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_SUB    = 8'h02;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_AND    = 8'h03;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_OR     = 8'h04;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_XOR    = 8'h05;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_SLL    = 8'h06;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_SRL    = 8'h07;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_SRA    = 8'h08;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_LUI    = 8'h09;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_PCADDU = 8'h0A;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_LD_W   = 8'h0B;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_ST_W   = 8'h0C;

    // result select, picks the execute unit
    localparam logic [ALU_SEL_WIDTH-1:0] SEL_NOP   = 3'd0;
    localparam logic [ALU_SEL_WIDTH-1:0] SEL_ARITH = 3'd1;
    localparam logic [ALU_SEL_WIDTH-1:0] SEL_LOGIC = 3'd2;
    localparam logic [ALU_SEL_WIDTH-1:0] SEL_SHIFT = 3'd3;
    localparam logic [ALU_SEL_WIDTH-1:0] SEL_MEM   = 3'd4;

endpackage

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage
    import core_types_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,

    // from fetch
    input  logic               in_valid_i,
    input  instr_buffer_info_t in_data_i,
    output logic               in_ready_o,

    // held instruction out to the decoders, results back
    output instr_buffer_info_t held_instr_o,
    input  logic [3:0]         match_i,
    input  decode_result_t     result_3r_i,
    input  decode_result_t     result_2ri8_i,
    input  decode_result_t     result_2ri12_i,
    input  decode_result_t     result_1ri20_i,

    // to issue
    output logic               out_valid_o,
    output decode_result_t     out_data_o,
    input  logic               out_ready_i
);

    logic               valid_q;
    instr_buffer_info_t instr_q;
    logic               accept;
    decode_result_t     merged;

    // register frees up in the same cycle it is drained
    assign in_ready_o = ~valid_q | out_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            instr_q <= in_data_i;
        end
    end

    assign held_instr_o = instr_q;

    // at most one decoder matches, the rest drive zero
    assign merged = result_3r_i | result_2ri8_i | result_2ri12_i | result_1ri20_i;

    always_comb begin
        out_data_o         = merged;
        out_data_o.illegal = ~(|match_i);
        out_data_o.pc      = instr_q.pc;
    end

    assign out_valid_o = valid_q;

endmodule

`default_nettype wire

/* logic/decoder_1ri20.sv */
`timescale 1ns/100ps
`default_nettype none

// 1RI20 format {opcode[7], si20[20], rd[5]}
module decoder_1ri20
    import core_types_pkg::*;
    import decode_ops_pkg::*;
(
    input  instr_buffer_info_t instr_info_i,
    output logic               match_o,
    output decode_result_t     result_o
);

    logic [DATA_WIDTH-1:0]     instr;
    logic [6:0]                opcode;
    logic [GPR_ADDR_WIDTH-1:0] rd;
    logic [19:0]               si20;

    assign instr  = instr_info_i.instr;
    assign opcode = instr[31:25];
    assign rd     = instr[4:0];
    assign si20   = instr[24:5];

    always_comb begin
        // no register source, upper immediate only
        match_o                  = 1'b1;
        result_o                 = '0;
        result_o.reg_write_valid = 1'b1;
        result_o.reg_write_addr  = rd;
        result_o.use_imm         = 1'b1;
        result_o.imm             = {si20, 12'b0};
        result_o.alusel          = SEL_ARITH;
        case (opcode)
            OPC_LU12I_W:   result_o.aluop = ALU_OP_LUI;
            // execute adds the pc to the immediate
            OPC_PCADDU12I: result_o.aluop = ALU_OP_PCADDU;
            default: begin
                match_o  = 1'b0;
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/decoder_2ri12.sv */
`timescale 1ns/100ps
`default_nettype none

// 2RI12 format {opcode[10], si12[12], rj[5], rd[5]}
module decoder_2ri12
    import core_types_pkg::*;
    import decode_ops_pkg::*;
(
    input  instr_buffer_info_t instr_info_i,
    output logic               match_o,
    output decode_result_t     result_o
);

    logic [DATA_WIDTH-1:0]     instr;
    logic [9:0]                opcode;
    logic [GPR_ADDR_WIDTH-1:0] rd;
    logic [GPR_ADDR_WIDTH-1:0] rj;
    logic [11:0]               si12;
    logic [DATA_WIDTH-1:0]     imm_sext;
    logic [DATA_WIDTH-1:0]     imm_zext;

    assign instr    = instr_info_i.instr;
    assign opcode   = instr[31:22];
    assign rd       = instr[4:0];
    assign rj       = instr[9:5];
    assign si12     = instr[21:10];
    assign imm_sext = {{(DATA_WIDTH-12){si12[11]}}, si12};
    assign imm_zext = {{(DATA_WIDTH-12){1'b0}}, si12};

    always_comb begin
        // rj source, rd target, immediate operand
        match_o                  = 1'b1;
        result_o                 = '0;
        result_o.reg_read_valid  = 2'b01;
        result_o.reg_read_addr   = {{GPR_ADDR_WIDTH{1'b0}}, rj};
        result_o.reg_write_valid = 1'b1;
        result_o.reg_write_addr  = rd;
        result_o.use_imm         = 1'b1;
        result_o.imm             = imm_sext;
        case (opcode)
            OPC_ADDI_W: begin
                result_o.aluop  = ALU_OP_ADD;
                result_o.alusel = SEL_ARITH;
            end
            // logic immediates are zero extended
            OPC_ANDI: begin
                result_o.imm    = imm_zext;
                result_o.aluop  = ALU_OP_AND;
                result_o.alusel = SEL_LOGIC;
            end
            OPC_ORI: begin
                result_o.imm    = imm_zext;
                result_o.aluop  = ALU_OP_OR;
                result_o.alusel = SEL_LOGIC;
            end
            OPC_XORI: begin
                result_o.imm    = imm_zext;
                result_o.aluop  = ALU_OP_XOR;
                result_o.alusel = SEL_LOGIC;
            end
            OPC_LD_W: begin
                result_o.aluop  = ALU_OP_LD_W;
                result_o.alusel = SEL_MEM;
            end
            OPC_ST_W: begin
                // store data comes from rd, carried in the rk slot
                result_o.reg_read_valid  = 2'b11;
                result_o.reg_read_addr   = {rd, rj};
                result_o.reg_write_valid = 1'b0;
                result_o.reg_write_addr  = '0;
                result_o.aluop           = ALU_OP_ST_W;
                result_o.alusel          = SEL_MEM;
            end
            default: begin
                match_o  = 1'b0;
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/decoder_2ri8.sv */
`timescale 1ns/100ps
`default_nettype none

// shift by immediate {opcode[17], ui5[5], rj[5], rd[5]}
module decoder_2ri8
    import core_types_pkg::*;
    import decode_ops_pkg::*;
(
    input  instr_buffer_info_t instr_info_i,
    output logic               match_o,
    output decode_result_t     result_o
);

    logic [DATA_WIDTH-1:0]     instr;
    logic [16:0]               opcode;
    logic [GPR_ADDR_WIDTH-1:0] rd;
    logic [GPR_ADDR_WIDTH-1:0] rj;
    logic [4:0]                ui5;

    assign instr  = instr_info_i.instr;
    assign opcode = instr[31:15];
    assign rd     = instr[4:0];
    assign rj     = instr[9:5];
    assign ui5    = instr[14:10];

    always_comb begin
        match_o                  = 1'b1;
        result_o                 = '0;
        result_o.reg_read_valid  = 2'b01;
        result_o.reg_read_addr   = {{GPR_ADDR_WIDTH{1'b0}}, rj};
        result_o.reg_write_valid = 1'b1;
        result_o.reg_write_addr  = rd;
        result_o.use_imm         = 1'b1;
        result_o.imm             = {{(DATA_WIDTH-5){1'b0}}, ui5};
        result_o.alusel          = SEL_SHIFT;
        case (opcode)
            OPC_SLLI_W: result_o.aluop = ALU_OP_SLL;
            OPC_SRLI_W: result_o.aluop = ALU_OP_SRL;
            OPC_SRAI_W: result_o.aluop = ALU_OP_SRA;
            default: begin
                match_o  = 1'b0;
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/decoder_3r.sv */
`timescale 1ns/100ps
`default_nettype none

// 3R format {opcode[17], rk[5], rj[5], rd[5]}
module decoder_3r
    import core_types_pkg::*;
    import decode_ops_pkg::*;
(
    input  instr_buffer_info_t instr_info_i,
    output logic               match_o,
    output decode_result_t     result_o
);

    logic [DATA_WIDTH-1:0]     instr;
    logic [16:0]               opcode;
    logic [GPR_ADDR_WIDTH-1:0] rd;
    logic [GPR_ADDR_WIDTH-1:0] rj;
    logic [GPR_ADDR_WIDTH-1:0] rk;

    assign instr  = instr_info_i.instr;
    assign opcode = instr[31:15];
    assign rd     = instr[4:0];
    assign rj     = instr[9:5];
    assign rk     = instr[14:10];

    always_comb begin
        // common to every 3R op
        match_o                  = 1'b1;
        result_o                 = '0;
        result_o.reg_read_valid  = 2'b11;
        result_o.reg_read_addr   = {rk, rj};
        result_o.reg_write_valid = 1'b1;
        result_o.reg_write_addr  = rd;
        case (opcode)
            OPC_ADD_W: begin
                result_o.aluop  = ALU_OP_ADD;
                result_o.alusel = SEL_ARITH;
            end
            OPC_SUB_W: begin
                result_o.aluop  = ALU_OP_SUB;
                result_o.alusel = SEL_ARITH;
            end
            OPC_AND: begin
                result_o.aluop  = ALU_OP_AND;
                result_o.alusel = SEL_LOGIC;
            end
            OPC_OR: begin
                result_o.aluop  = ALU_OP_OR;
                result_o.alusel = SEL_LOGIC;
            end
            OPC_XOR: begin
                result_o.aluop  = ALU_OP_XOR;
                result_o.alusel = SEL_LOGIC;
            end
            OPC_SLL_W: begin
                result_o.aluop  = ALU_OP_SLL;
                result_o.alusel = SEL_SHIFT;
            end
            OPC_SRL_W: begin
                result_o.aluop  = ALU_OP_SRL;
                result_o.alusel = SEL_SHIFT;
            end
            OPC_SRA_W: begin
                result_o.aluop  = ALU_OP_SRA;
                result_o.alusel = SEL_SHIFT;
            end
            default: begin
                // not ours, stay silent so the stage can OR results
                match_o  = 1'b0;
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/instr_decode_top.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decode_top
    import core_types_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               in_valid_i,
    input  instr_buffer_info_t in_data_i,
    output logic               in_ready_o,
    output logic               out_valid_o,
    output decode_result_t     out_data_o,
    input  logic               out_ready_i
);

    instr_buffer_info_t held_instr;
    logic               match_3r;
    logic               match_2ri8;
    logic               match_2ri12;
    logic               match_1ri20;
    decode_result_t     result_3r;
    decode_result_t     result_2ri8;
    decode_result_t     result_2ri12;
    decode_result_t     result_1ri20;

    decode_stage i_decode_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_data_i      (in_data_i),
        .in_ready_o     (in_ready_o),
        .held_instr_o   (held_instr),
        .match_i        ({match_1ri20, match_2ri12, match_2ri8, match_3r}),
        .result_3r_i    (result_3r),
        .result_2ri8_i  (result_2ri8),
        .result_2ri12_i (result_2ri12),
        .result_1ri20_i (result_1ri20),
        .out_valid_o    (out_valid_o),
        .out_data_o     (out_data_o),
        .out_ready_i    (out_ready_i)
    );

    // all four formats look at the held word in parallel
    decoder_3r i_decoder_3r (
        .instr_info_i (held_instr),
        .match_o      (match_3r),
        .result_o     (result_3r)
    );

    decoder_2ri8 i_decoder_2ri8 (
        .instr_info_i (held_instr),
        .match_o      (match_2ri8),
        .result_o     (result_2ri8)
    );

    decoder_2ri12 i_decoder_2ri12 (
        .instr_info_i (held_instr),
        .match_o      (match_2ri12),
        .result_o     (result_2ri12)
    );

    decoder_1ri20 i_decoder_1ri20 (
        .instr_info_i (held_instr),
        .match_o      (match_1ri20),
        .result_o     (result_1ri20)
    );

endmodule

`default_nettype wire
